/* tb.f */
+incdir+include
verilog/eeprom_pkg.sv
verilog/axil_regs.sv
verilog/eeprom_seq.sv
verilog/i2c_bit_engine.sv
verilog/eeprom_ctrl_top.sv
verif/eeprom_slave_model.sv
verif/tb_eeprom_ctrl.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing
TOP       := tb_eeprom_ctrl
FILELIST  := tb.f
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "TB PASSED" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)

/* verif/tb_eeprom_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "eeprom_consts.svh"

module tb_eeprom_ctrl
    import eeprom_pkg::*;
();

    logic        CLK;
    logic        RESET;
    axil_req_t   axil_in;
    axil_rsp_t   axil_out;
    logic        scl;
    logic        dut_low;
    logic        model_low;
    logic        sda_line;
    logic        force_nack;
    int          stop_count;
    int          errors;
    logic [15:0] lfsr;
    logic [7:0]  ref_mem [0:2047];

    assign sda_line = !(dut_low || model_low); // open-drain wired AND

    eeprom_ctrl_top DUT (
        .CLK           (CLK),
        .RESET         (RESET),
        .axil_in       (axil_in),
        .axil_out      (axil_out),
        .scl           (scl),
        .sda_drive_low (dut_low),
        .sda_in        (sda_line)
    );

    eeprom_slave_model u_eeprom (
        .CLK           (CLK),
        .RESET         (RESET),
        .scl           (scl),
        .sda           (sda_line),
        .force_nack    (force_nack),
        .sda_drive_low (model_low),
        .stop_count    (stop_count)
    );

    initial
    begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    // one lfsr step per bit, taps 16 14 13 11
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        int          i;
        v = 32'd0;
        for (i = 0; i < n; i++)
        begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
        assert (exp === got)
        else
        begin
            $display("FAILED time=%0t %s expected=%h actual=%h", $time, name, exp, got);
            errors++;
        end
    endtask

    task automatic report_error(input string msg);
        $display("ERROR time=%0t %s", $time, msg);
        errors++;
    endtask

    task automatic axi_write(input logic [3:0] addr, input logic [31:0] data, input int stall);
        int t;
        int i;
        @(posedge CLK);
        axil_in.awaddr  <= addr;
        axil_in.wdata   <= data;
        axil_in.wstrb   <= 4'hF;
        axil_in.awvalid <= 1'b1;
        axil_in.wvalid  <= 1'b1;
        t = 0;
        do
        begin
            @(posedge CLK);
            t++;
        end
        while (!axil_out.awready && t < 50);
        if (!axil_out.awready)
            report_error("write address and data were never accepted");
        check_value("wready", 32'd1, 32'(axil_out.wready)); // taken together with awready
        axil_in.awvalid <= 1'b0;
        axil_in.wvalid  <= 1'b0;
        t = 0;
        while (!axil_out.bvalid && t < 50)
        begin
            @(posedge CLK);
            t++;
        end
        if (!axil_out.bvalid)
            report_error("no write response arrived");
        check_value("bresp", 32'd0, 32'(axil_out.bresp));
        for (i = 0; i < stall; i++)
        begin
            @(posedge CLK);
            check_value("bvalid", 32'd1, 32'(axil_out.bvalid));
        end
        axil_in.bready <= 1'b1;
        @(posedge CLK);
        axil_in.bready <= 1'b0;
    endtask

    task automatic axi_read(input logic [3:0] addr, input int stall, output logic [31:0] data);
        int t;
        int i;
        @(posedge CLK);
        axil_in.araddr  <= addr;
        axil_in.arvalid <= 1'b1;
        t = 0;
        do
        begin
            @(posedge CLK);
            t++;
        end
        while (!axil_out.arready && t < 50);
        if (!axil_out.arready)
            report_error("read address was never accepted");
        axil_in.arvalid <= 1'b0;
        t = 0;
        while (!axil_out.rvalid && t < 50)
        begin
            @(posedge CLK);
            t++;
        end
        if (!axil_out.rvalid)
            report_error("no read data arrived");
        check_value("rresp", 32'd0, 32'(axil_out.rresp));
        data = axil_out.rdata;
        for (i = 0; i < stall; i++)
        begin
            @(posedge CLK);
            check_value("rvalid", 32'd1, 32'(axil_out.rvalid));
            check_value("rdata", data, axil_out.rdata);
        end
        axil_in.rready <= 1'b1;
        @(posedge CLK);
        axil_in.rready <= 1'b0;
    endtask

    task automatic wait_idle(output logic [31:0] status);
        int t;
        t = 0;
        do
        begin
            axi_read(`REG_STATUS, 0, status);
            t++;
        end
        while (status[0] && t < 400);
        if (status[0])
            report_error("busy never cleared");
    endtask

    task automatic ee_write(input logic [10:0] a, input logic [7:0] d, output logic [31:0] st);
        axi_write(`REG_ADDR, 32'(a), 0);
        axi_write(`REG_WDATA, 32'(d), 0);
        axi_write(`REG_CMD, 32'd1, 0);
        wait_idle(st);
    endtask

    task automatic ee_read(input logic [10:0] a, output logic [31:0] st);
        axi_write(`REG_ADDR, 32'(a), 0);
        axi_write(`REG_CMD, 32'd3, 0);
        wait_idle(st);
    endtask

    initial
    begin
        logic [31:0] r;
        logic [31:0] st;
        logic [10:0] a;
        logic [7:0]  d;
        int          n;
        int          sc0;
        RESET      <= 1'b1;
        axil_in    <= '0;
        force_nack <= 1'b0;
        lfsr       = 16'd89;
        errors     = 0;
        for (n = 0; n < 2048; n++)
            ref_mem[n] = 8'(n) ^ 8'h5A;
        repeat (4) @(posedge CLK);
        RESET <= 1'b0;

        check_value("scl", 32'd1, 32'(scl));
        check_value("sda_drive_low", 32'd0, 32'(dut_low));
        axi_read(`REG_STATUS, 0, r);
        check_value("status", 32'd0, r);

        st = rand_bits(32);
        axi_write(`REG_ADDR, st, 0);
        axi_read(`REG_ADDR, 0, r);
        check_value("addr_reg", st & 32'h7FF, r);
        st = rand_bits(32);
        axi_write(`REG_WDATA, st, 0);
        axi_read(`REG_WDATA, 0, r);
        check_value("wdata_reg", st & 32'hFF, r);
        axi_read(4'h2, 0, r); // no register at this offset
        check_value("unmapped", 32'd0, r);

        for (n = 0; n < 40; n++)
        begin
            r = rand_bits(12);
            a = r[10:0];
            if (r[11])
            begin
                ee_read(a, st);
                check_value("status.rdata", 32'(ref_mem[a]), 32'(st[15:8]));
            end
            else
            begin
                r = rand_bits(8);
                d = r[7:0];
                ee_write(a, d, st);
                ref_mem[a] = d;
            end
            check_value("status.nack", 32'd0, 32'(st[1]));
        end

        // slave refuses the control byte, nothing must be written
        r = rand_bits(11);
        a = r[10:0];
        force_nack <= 1'b1;
        ee_write(a, ~ref_mem[a], st);
        check_value("status.nack", 32'd1, 32'(st[1]));
        force_nack <= 1'b0;
        ee_read(a, st);
        check_value("status.nack", 32'd0, 32'(st[1]));
        check_value("status.rdata", 32'(ref_mem[a]), 32'(st[15:8]));

        r = rand_bits(19);
        a = r[10:0];
        d = r[18:11];
        sc0 = stop_count;
        axi_write(`REG_ADDR, 32'(a), 0);
        axi_write(`REG_WDATA, 32'(d), 0);
        axi_write(`REG_CMD, 32'd1, 0);
        axi_write(`REG_WDATA, 32'(~d), 0);
        axi_write(`REG_CMD, 32'd1, 0); // dropped, still busy
        wait_idle(st);
        repeat (70 * `SCL_HALF) @(posedge CLK); // longer than a whole write transaction
        axi_read(`REG_STATUS, 0, st);
        check_value("status.busy", 32'd0, 32'(st[0]));
        check_value("transactions", 32'd1, 32'(stop_count - sc0));
        ref_mem[a] = d;
        ee_read(a, st);
        check_value("status.rdata", 32'(ref_mem[a]), 32'(st[15:8]));

        r = rand_bits(11);
        axi_write(`REG_ADDR, r, 32'(1 + rand_bits(3)));
        axi_read(`REG_ADDR, 32'(1 + rand_bits(3)), st);
        check_value("addr_reg", r & 32'h7FF, st);
        axi_read(`REG_STATUS, 32'(1 + rand_bits(3)), st);
        check_value("status.busy", 32'd0, 32'(st[0]));

        $display("errors: %0d", errors);
        if (errors == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* verif/eeprom_slave_model.sv */
`timescale 1ns/1ps
`default_nettype none

module eeprom_slave_model (
    input  logic CLK,
    input  logic RESET,
    input  logic scl,
    input  logic sda,
    input  logic force_nack,
    output logic sda_drive_low,
    output int   stop_count
);

    typedef enum logic [2:0] {
        P_IDLE,
        P_DEV,
        P_ADDR,
        P_DATA,
        P_RD,
        P_IGN
    } phase_e;

    logic [7:0] mem [0:2047];
    logic       prev_scl;
    logic       prev_sda;
    logic [3:0] cnt;
    logic [7:0] sh;
    logic [7:0] tx;
    logic [2:0] page;
    logic [7:0] addr_lo;
    logic       go_rd;
    phase_e     ph;

    initial
    begin
        for (int i = 0; i < 2048; i++)
            mem[i] = 8'(i) ^ 8'h5A; // initial fill
    end

    always @(posedge CLK)
    begin
        prev_scl <= scl;
        prev_sda <= sda;
        if (RESET)
        begin
            ph            <= P_IDLE;
            cnt           <= 4'd0;
            go_rd         <= 1'b0;
            sda_drive_low <= 1'b0;
            stop_count    <= 0;
        end
        else if (prev_scl && scl && prev_sda && !sda) // start or repeated start
        begin
            ph            <= P_DEV;
            cnt           <= 4'd0;
            sda_drive_low <= 1'b0;
        end
        else if (prev_scl && scl && !prev_sda && sda) // stop
        begin
            ph            <= P_IDLE;
            sda_drive_low <= 1'b0;
            stop_count    <= stop_count + 1;
        end
        else if (!prev_scl && scl)
        begin
            if (cnt < 4'd8)
                sh <= {sh[6:0], sda};
            cnt <= cnt + 4'd1;
        end
        else if (prev_scl && !scl && (ph != P_IDLE))
        begin
            if (cnt == 4'd8)
            begin
                sda_drive_low <= 1'b0;
                case (ph)
                    P_DEV:
                    begin
                        page <= sh[3:1];
                        ph   <= sh[0] ? P_IGN : P_ADDR;
                        if ((sh[7:4] == 4'b1010) && !force_nack)
                        begin
                            sda_drive_low <= 1'b1;
                            go_rd         <= sh[0];
                        end
                        else
                            ph <= P_IGN;
                    end
                    P_ADDR:
                    begin
                        addr_lo       <= sh;
                        sda_drive_low <= !force_nack;
                        ph            <= P_DATA;
                    end
                    P_DATA:
                    begin
                        if (!force_nack)
                        begin
                            mem[{page, addr_lo}] <= sh;
                            sda_drive_low        <= 1'b1;
                        end
                        ph <= P_IGN;
                    end
                    P_RD:    ph <= P_IGN; // master acks here
                    default: ph <= P_IGN;
                endcase
            end
            else if (cnt == 4'd9)
            begin
                sda_drive_low <= 1'b0;
                cnt           <= 4'd0;
                if (go_rd)
                begin
                    go_rd         <= 1'b0;
                    ph            <= P_RD;
                    tx            <= mem[{page, addr_lo}];
                    sda_drive_low <= !mem[{page, addr_lo}][7];
                end
            end
            else if ((ph == P_RD) && (cnt != 4'd0))
            begin
                sda_drive_low <= !tx[6];
                tx            <= {tx[6:0], 1'b0};
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/eeprom_ctrl_top.sv */
`timescale 1ns/1ps
`default_nettype none

module eeprom_ctrl_top
    import eeprom_pkg::*;
(
    input  logic      CLK,
    input  logic      RESET,
    input  axil_req_t axil_in,
    output axil_rsp_t axil_out,
    output logic      scl,
    output logic      sda_drive_low,
    input  logic      sda_in
);

    logic     req_valid;
    logic     req_ready;
    ee_req_t  req;
    logic     rsp_valid;
    ee_rsp_t  rsp;
    logic     bit_valid;
    logic     bit_ready;
    bit_req_t bit_req;
    logic     bit_done;
    bit_rsp_t bit_rsp;

    axil_regs u_regs (
        .CLK       (CLK),
        .RESET     (RESET),
        .axil_in   (axil_in),
        .axil_out  (axil_out),
        .req_valid (req_valid),
        .req       (req),
        .req_ready (req_ready),
        .rsp_valid (rsp_valid),
        .rsp       (rsp)
    );

    eeprom_seq u_seq (
        .CLK       (CLK),
        .RESET     (RESET),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req       (req),
        .rsp_valid (rsp_valid),
        .rsp       (rsp),
        .bit_valid (bit_valid),
        .bit_req   (bit_req),
        .bit_ready (bit_ready),
        .bit_done  (bit_done),
        .bit_rsp   (bit_rsp)
    );

    i2c_bit_engine u_bit (
        .CLK           (CLK),
        .RESET         (RESET),
        .bit_valid     (bit_valid),
        .bit_ready     (bit_ready),
        .bit_req       (bit_req),
        .bit_done      (bit_done),
        .bit_rsp       (bit_rsp),
        .scl           (scl),
        .sda_drive_low (sda_drive_low),
        .sda_in        (sda_in)
    );

endmodule

`default_nettype wire

/* verilog/i2c_bit_engine.sv */
`timescale 1ns/1ps
`default_nettype none

`include "eeprom_consts.svh"

module i2c_bit_engine
    import eeprom_pkg::*;
(
    input  logic     CLK,
    input  logic     RESET,
    input  logic     bit_valid,
    output logic     bit_ready,
    input  bit_req_t bit_req,
    output logic     bit_done,
    output bit_rsp_t bit_rsp,
    output logic     scl,
    output logic     sda_drive_low,
    input  logic     sda_in
);

    typedef enum logic [2:0] {
        E_IDLE,
        E_START,
        E_STOP,
        E_BIT_LOW,
        E_BIT_HIGH,
        E_DONE
    } state_e;

    localparam int unsigned HALF = `SCL_HALF;
    localparam logic [3:0] MID       = 4'(HALF / 2 - 1); // sda update / sample point
    localparam logic [3:0] HALF_END  = 4'(HALF - 1);
    localparam logic [3:0] FULL_END  = 4'(2 * HALF - 1);
    localparam logic [3:0] LAST_BIT  = 4'd8;             // ack slot

    state_e     state_q;
    logic [3:0] phase_q;
    logic [3:0] bit_cnt_q;
    bit_cmd_e   cmd_q;
    logic [7:0] tx_q;
    logic [7:0] rx_q;
    logic       mnack_q;
    logic       ack_q;
    logic       drive_bit;

    assign bit_ready          = (state_q == E_IDLE);
    assign bit_done           = (state_q == E_DONE);
    assign bit_rsp.rx_byte    = rx_q;
    assign bit_rsp.slave_nack = ack_q;

    // data bits go out msb first, the ninth slot is the ack
    always_comb
    begin
        if (bit_cnt_q < LAST_BIT)
            drive_bit = (cmd_q == BC_WRITE) && !tx_q[7];
        else
            drive_bit = (cmd_q == BC_READ) && !mnack_q;
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state_q       <= E_IDLE;
            phase_q       <= 4'd0;
            bit_cnt_q     <= 4'd0;
            scl           <= 1'b1;
            sda_drive_low <= 1'b0;
        end
        else
        begin
            case (state_q)
                E_IDLE:
                begin
                    if (bit_valid)
                    begin
                        phase_q   <= 4'd0;
                        bit_cnt_q <= 4'd0;
                        case (bit_req.cmd)
                            BC_START:
                            begin
                                sda_drive_low <= 1'b0; // release before scl rises
                                state_q       <= E_START;
                            end
                            BC_STOP:
                            begin
                                sda_drive_low <= 1'b1; // scl is low here
                                state_q       <= E_STOP;
                            end
                            default:
                            begin
                                scl     <= 1'b0;
                                state_q <= E_BIT_LOW;
                            end
                        endcase
                    end
                end
                E_START:
                begin
                    phase_q <= phase_q + 4'd1;
                    if (phase_q == MID)
                        scl <= 1'b1;
                    if (phase_q == HALF_END)
                        sda_drive_low <= 1'b1; // sda falls with scl high
                    if (phase_q == FULL_END)
                    begin
                        scl     <= 1'b0;
                        state_q <= E_DONE;
                    end
                end
                E_STOP:
                begin
                    phase_q <= phase_q + 4'd1;
                    if (phase_q == MID)
                        scl <= 1'b1;
                    if (phase_q == HALF_END)
                        sda_drive_low <= 1'b0; // sda rises with scl high
                    if (phase_q == FULL_END)
                        state_q <= E_DONE;
                end
                E_BIT_LOW:
                begin
                    phase_q <= phase_q + 4'd1;
                    if (phase_q == MID)
                        sda_drive_low <= drive_bit;
                    if (phase_q == HALF_END)
                    begin
                        scl     <= 1'b1;
                        phase_q <= 4'd0;
                        state_q <= E_BIT_HIGH;
                    end
                end
                E_BIT_HIGH:
                begin
                    phase_q <= phase_q + 4'd1;
                    if (phase_q == HALF_END)
                    begin
                        scl     <= 1'b0;
                        phase_q <= 4'd0;
                        if (bit_cnt_q == LAST_BIT)
                            state_q <= E_DONE;
                        else
                        begin
                            bit_cnt_q <= bit_cnt_q + 4'd1;
                            state_q   <= E_BIT_LOW;
                        end
                    end
                end
                default: state_q <= E_IDLE; // E_DONE
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if ((state_q == E_IDLE) && bit_valid)
        begin
            cmd_q   <= bit_req.cmd;
            tx_q    <= bit_req.tx_byte;
            mnack_q <= bit_req.master_nack;
        end
        else if ((state_q == E_BIT_LOW) && (phase_q == MID) && (bit_cnt_q < LAST_BIT))
            tx_q <= {tx_q[6:0], 1'b0};

        // sample in the middle of scl high
        if ((state_q == E_BIT_HIGH) && (phase_q == MID))
        begin
            if (bit_cnt_q < LAST_BIT)
                rx_q <= {rx_q[6:0], sda_in};
            else
                ack_q <= sda_in;
        end
    end

endmodule

`default_nettype wire

/* verilog/eeprom_seq.sv */
`timescale 1ns/1ps
`default_nettype none

`include "eeprom_consts.svh"

module eeprom_seq
    import eeprom_pkg::*;
(
    input  logic     CLK,
    input  logic     RESET,
    input  logic     req_valid,
    output logic     req_ready,
    input  ee_req_t  req,
    output logic     rsp_valid,
    output ee_rsp_t  rsp,
    output logic     bit_valid,
    output bit_req_t bit_req,
    input  logic     bit_ready,
    input  logic     bit_done,
    input  bit_rsp_t bit_rsp
);

    typedef enum logic [3:0] {
        S_IDLE,
        S_START,
        S_CTRL_WR,
        S_ADDR,
        S_DATA_WR,
        S_RSTART,
        S_CTRL_RD,
        S_DATA_RD,
        S_STOP,
        S_RESP
    } state_e;

    state_e     state_q;
    state_e     state_next;
    logic       issued_q; // step handed to the bit engine, waiting for done
    logic       nack_q;
    logic       wr_nack;
    ee_req_t    req_q;
    logic [7:0] rdata_q;
    logic [2:0] page;

    assign page = req_q.addr[`EE_ADDR_W-1:8];

    assign req_ready = (state_q == S_IDLE);
    assign rsp_valid = (state_q == S_RESP);
    assign rsp.rdata = rdata_q;
    assign rsp.nack  = nack_q;

    assign bit_valid = !issued_q && (state_q != S_IDLE) && (state_q != S_RESP);

    always_comb
    begin
        bit_req.cmd         = BC_WRITE;
        bit_req.tx_byte     = 8'h00;
        bit_req.master_nack = 1'b0;
        case (state_q)
            S_START,
            S_RSTART:  bit_req.cmd = BC_START;
            S_CTRL_WR: bit_req.tx_byte = {`EE_DEV_CODE, page, 1'b0};
            S_ADDR:    bit_req.tx_byte = req_q.addr[7:0];
            S_DATA_WR: bit_req.tx_byte = req_q.wdata;
            S_CTRL_RD: bit_req.tx_byte = {`EE_DEV_CODE, page, 1'b1};
            S_DATA_RD:
            begin
                bit_req.cmd         = BC_READ;
                bit_req.master_nack = 1'b1; // single byte, so always the last one
            end
            S_STOP:    bit_req.cmd = BC_STOP;
            default:   bit_req.cmd = BC_WRITE;
        endcase
    end

    // slave nack only matters on bytes we sent
    assign wr_nack = bit_rsp.slave_nack && ((state_q == S_CTRL_WR) || (state_q == S_ADDR)
                     || (state_q == S_DATA_WR) || (state_q == S_CTRL_RD));

    always_comb
    begin
        case (state_q)
            S_START:   state_next = S_CTRL_WR;
            S_CTRL_WR: state_next = S_ADDR;
            S_ADDR:    state_next = (req_q.op == EE_READ) ? S_RSTART : S_DATA_WR;
            S_DATA_WR: state_next = S_STOP;
            S_RSTART:  state_next = S_CTRL_RD;
            S_CTRL_RD: state_next = S_DATA_RD;
            S_DATA_RD: state_next = S_STOP;
            S_STOP:    state_next = S_RESP;
            default:   state_next = S_IDLE;
        endcase
        if (wr_nack)
            state_next = S_STOP;
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state_q  <= S_IDLE;
            issued_q <= 1'b0;
            nack_q   <= 1'b0;
        end
        else
        begin
            if (bit_valid && bit_ready)
                issued_q <= 1'b1;

            case (state_q)
                S_IDLE:
                begin
                    if (req_valid)
                    begin
                        nack_q  <= 1'b0;
                        state_q <= S_START;
                    end
                end
                S_RESP:  state_q <= S_IDLE;
                default:
                begin
                    if (bit_done)
                    begin
                        issued_q <= 1'b0;
                        state_q  <= state_next;
                        if (wr_nack)
                            nack_q <= 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if (req_valid && req_ready)
            req_q <= req;
        if ((state_q == S_DATA_RD) && bit_done)
            rdata_q <= bit_rsp.rx_byte;
    end

endmodule

`default_nettype wire

/* verilog/axil_regs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "eeprom_consts.svh"

module axil_regs
    import eeprom_pkg::*;
(
    input  logic      CLK,
    input  logic      RESET,
    input  axil_req_t axil_in,
    output axil_rsp_t axil_out,
    output logic      req_valid,
    output ee_req_t   req,
    input  logic      req_ready,
    input  logic      rsp_valid,
    input  ee_rsp_t   rsp
);

    logic                  wr_fire;
    logic                  rd_fire;
    logic                  cmd_go;
    logic                  bvalid_q;
    logic                  rvalid_q;
    logic [31:0]           rdata_q;
    logic [31:0]           rd_mux;
    logic [`EE_ADDR_W-1:0] addr_q;
    logic [7:0]            wdata_q;
    ee_op_e                op_q;
    logic                  busy_q;
    logic                  nack_q;
    logic [7:0]            rd_byte_q;

    // address and data are taken together, and never with a response pending
    assign wr_fire = axil_in.awvalid && axil_in.wvalid && !bvalid_q;
    assign rd_fire = axil_in.arvalid && !rvalid_q;

    // start bit set, dropped while a transaction runs
    assign cmd_go = wr_fire && (axil_in.awaddr == `REG_CMD) && axil_in.wstrb[0]
                    && axil_in.wdata[0] && !busy_q;

    always_comb
    begin
        axil_out.awready = wr_fire;
        axil_out.wready  = wr_fire;
        axil_out.bvalid  = bvalid_q;
        axil_out.bresp   = 2'b00; // OKAY
        axil_out.arready = !rvalid_q;
        axil_out.rvalid  = rvalid_q;
        axil_out.rdata   = rdata_q;
        axil_out.rresp   = 2'b00;
    end

    always_comb
    begin
        case (axil_in.araddr)
            `REG_CMD:    rd_mux = {30'd0, op_q, 1'b0};
            `REG_ADDR:   rd_mux = {{(32 - `EE_ADDR_W){1'b0}}, addr_q};
            `REG_WDATA:  rd_mux = {24'd0, wdata_q};
            `REG_STATUS: rd_mux = {16'd0, rd_byte_q, 6'd0, nack_q, busy_q};
            default:     rd_mux = 32'd0;
        endcase
    end

    assign req.op    = op_q;
    assign req.addr  = addr_q;
    assign req.wdata = wdata_q;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            bvalid_q  <= 1'b0;
            rvalid_q  <= 1'b0;
            req_valid <= 1'b0;
            busy_q    <= 1'b0;
            nack_q    <= 1'b0;
            rd_byte_q <= 8'd0;
        end
        else
        begin
            if (wr_fire)
                bvalid_q <= 1'b1;
            else if (axil_in.bready)
                bvalid_q <= 1'b0;

            if (rd_fire)
                rvalid_q <= 1'b1;
            else if (axil_in.rready)
                rvalid_q <= 1'b0;

            if (cmd_go)
            begin
                req_valid <= 1'b1;
                busy_q    <= 1'b1;
            end
            else if (req_valid && req_ready)
                req_valid <= 1'b0;

            // busy blocks new commands, so this never meets cmd_go
            if (rsp_valid)
            begin
                busy_q    <= 1'b0;
                nack_q    <= rsp.nack;
                rd_byte_q <= rsp.rdata;
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (rd_fire)
            rdata_q <= rd_mux;

        if (wr_fire && (axil_in.awaddr == `REG_ADDR))
        begin
            if (axil_in.wstrb[0])
                addr_q[7:0] <= axil_in.wdata[7:0];
            if (axil_in.wstrb[1])
                addr_q[`EE_ADDR_W-1:8] <= axil_in.wdata[`EE_ADDR_W-1:8];
        end

        if (wr_fire && (axil_in.awaddr == `REG_WDATA) && axil_in.wstrb[0])
            wdata_q <= axil_in.wdata[7:0];

        if (cmd_go)
            op_q <= ee_op_e'(axil_in.wdata[1]); // 1 = random read
    end

endmodule

`default_nettype wire

/* verilog/eeprom_pkg.sv */
`default_nettype none

`include "eeprom_consts.svh"

package eeprom_pkg;

    typedef enum logic {
        EE_WRITE = 1'b0,
        EE_READ  = 1'b1
    } ee_op_e;

    typedef struct packed {
        ee_op_e                op;
        logic [`EE_ADDR_W-1:0] addr;
        logic [7:0]            wdata;
    } ee_req_t;

    typedef struct packed {
        logic [7:0] rdata;
        logic       nack;
    } ee_rsp_t;

    typedef enum logic [1:0] {
        BC_START,
        BC_STOP,
        BC_WRITE,
        BC_READ
    } bit_cmd_e;

    typedef struct packed {
        bit_cmd_e   cmd;
        logic [7:0] tx_byte;
        logic       master_nack; // ack bit sent by master after a read byte
    } bit_req_t;

    typedef struct packed {
        logic [7:0] rx_byte;
        logic       slave_nack;
    } bit_rsp_t;

    typedef struct packed {
        logic [3:0]  awaddr;
        logic        awvalid;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic        wvalid;
        logic        bready;
        logic [3:0]  araddr;
        logic        arvalid;
        logic        rready;
    } axil_req_t;

    typedef struct packed {
        logic        awready;
        logic        wready;
        logic        bvalid;
        logic [1:0]  bresp;
        logic        arready;
        logic        rvalid;
        logic [31:0] rdata;
        logic [1:0]  rresp;
    } axil_rsp_t;

endpackage

`default_nettype wire

/* include/eeprom_consts.svh */
`ifndef EEPROM_CONSTS_SVH
`define EEPROM_CONSTS_SVH

// 24C16 device code, upper nibble of every control byte
`define EE_DEV_CODE 4'b1010

// 2K x 8 array
`define EE_ADDR_W 11

`define SCL_HALF 4 // CLK cycles per half SCL period

// AXI4-Lite register byte offsets
`define REG_CMD    4'h0
`define REG_ADDR   4'h4
`define REG_WDATA  4'h8
`define REG_STATUS 4'hC

`endif
